//--- design/cnn_pkg.sv
package cnn_pkg;

    // **************************************************
    // network sizes
    // **************************************************
    localparam int IMG_DIM    = 8;                        // image side
    localparam int KER_DIM    = 3;                        // kernel side
    localparam int CONV_DIM   = IMG_DIM - KER_DIM + 1;    // valid windows per side
    localparam int POOL_DIM   = CONV_DIM / 2;             // after 2x2 max
    localparam int NUM_FEAT   = POOL_DIM * POOL_DIM;      // 9 pooled features
    localparam int NUM_CLASS  = 4;

    // word widths
    localparam int PIX_W      = 8;    // pixel, weight, feature
    localparam int BIAS_W     = 16;
    localparam int ACC_W      = 32;   // accumulators and scores
    localparam int SHIFT_W    = 4;
    localparam int FEAT_IDX_W = 4;
    localparam int CLASS_W    = 2;
    localparam int WB_ADR_W   = 8;    // word address
    localparam int WB_DAT_W   = 32;

    // requant limits, signed 8 bit
    localparam int SAT_MAX    = 127;
    localparam int SAT_MIN    = -128;

    // **************************************************
    // register map, word addresses
    // **************************************************
    localparam logic [WB_ADR_W-1:0] ADR_CTRL       = 8'h00;  // bit 0 start
    localparam logic [WB_ADR_W-1:0] ADR_STATUS     = 8'h01;  // bit 0 busy, bit 1 done
    localparam logic [WB_ADR_W-1:0] ADR_CONV_BIAS  = 8'h02;
    localparam logic [WB_ADR_W-1:0] ADR_CONV_SHIFT = 8'h03;
    localparam logic [WB_ADR_W-1:0] ADR_RESULT     = 8'h04;  // class index
    localparam logic [WB_ADR_W-1:0] ADR_FILT_BASE  = 8'h08;  // 9 taps, row-major, up to 0x10
    localparam logic [WB_ADR_W-1:0] ADR_SCORE_BASE = 8'h14;  // 4 scores, read only
    localparam logic [WB_ADR_W-1:0] ADR_DBIAS_BASE = 8'h18;  // 4 dense biases, clear of the taps
    localparam logic [WB_ADR_W-1:0] ADR_DWGT_BASE  = 8'h40;  // class * 9 + feature
    localparam logic [WB_ADR_W-1:0] ADR_IMG_BASE   = 8'h80;  // 64 pixels, row-major

endpackage

//--- design/cnn_regs.sv
module cnn_regs (
    input  logic                                              clk,
    input  logic                                              rst,
    input  logic                                              wb_cyc,
    input  logic                                              wb_stb,
    input  logic                                              wb_we,
    input  logic [cnn_pkg::WB_ADR_W-1:0]                      wb_adr,
    input  logic [cnn_pkg::WB_DAT_W-1:0]                      wb_dat_w,
    output logic [cnn_pkg::WB_DAT_W-1:0]                      wb_dat_r,
    output logic                                              wb_ack,
    output logic                                              start,
    output logic [cnn_pkg::IMG_DIM*cnn_pkg::IMG_DIM*cnn_pkg::PIX_W-1:0] image,
    output logic [cnn_pkg::KER_DIM*cnn_pkg::KER_DIM*cnn_pkg::PIX_W-1:0] filt_weights,
    output logic [cnn_pkg::BIAS_W-1:0]                        conv_bias,
    output logic [cnn_pkg::SHIFT_W-1:0]                       conv_shift,
    output logic [cnn_pkg::NUM_CLASS*cnn_pkg::NUM_FEAT*cnn_pkg::PIX_W-1:0] dense_weights,
    output logic [cnn_pkg::NUM_CLASS*cnn_pkg::BIAS_W-1:0]     dense_biases,
    input  logic                                              done,
    input  logic [cnn_pkg::CLASS_W-1:0]                       result_class,
    input  logic [cnn_pkg::NUM_CLASS*cnn_pkg::ACC_W-1:0]      scores
);
    import cnn_pkg::*;

    logic                         wb_req;     // new cycle, not yet acked
    logic                         wr_en;      // config write allowed
    logic                         start_req;
    logic                         busy;
    logic                         done_st;
    logic [CLASS_W-1:0]           class_q;    // captured on done
    logic [NUM_CLASS*ACC_W-1:0]   score_q;
    logic [WB_ADR_W-1:0]          off_filt;
    logic [WB_ADR_W-1:0]          off_score;
    logic [WB_ADR_W-1:0]          off_dbias;
    logic [WB_ADR_W-1:0]          off_dwgt;
    logic [WB_ADR_W-1:0]          off_img;
    logic                         in_filt;
    logic                         in_score;
    logic                         in_dbias;
    logic                         in_dwgt;
    logic                         in_img;
    logic [WB_DAT_W-1:0]          rd_data;

    assign wb_req    = wb_cyc & wb_stb & ~wb_ack;   // ack goes out next cycle
    assign wr_en     = wb_req & wb_we & ~busy;      // config frozen during a run
    assign start_req = wr_en & (wb_adr == ADR_CTRL) & wb_dat_w[0];

    // **************************************************
    // address decode of the array regions
    // **************************************************
    assign off_filt  = wb_adr - ADR_FILT_BASE;
    assign off_score = wb_adr - ADR_SCORE_BASE;
    assign off_dbias = wb_adr - ADR_DBIAS_BASE;
    assign off_dwgt  = wb_adr - ADR_DWGT_BASE;
    assign off_img   = wb_adr - ADR_IMG_BASE;

    assign in_filt  = (wb_adr >= ADR_FILT_BASE)  & (off_filt  < WB_ADR_W'(KER_DIM*KER_DIM));
    assign in_score = (wb_adr >= ADR_SCORE_BASE) & (off_score < WB_ADR_W'(NUM_CLASS));
    assign in_dbias = (wb_adr >= ADR_DBIAS_BASE) & (off_dbias < WB_ADR_W'(NUM_CLASS));
    assign in_dwgt  = (wb_adr >= ADR_DWGT_BASE)  & (off_dwgt  < WB_ADR_W'(NUM_CLASS*NUM_FEAT));
    assign in_img   = (wb_adr >= ADR_IMG_BASE)   & (off_img   < WB_ADR_W'(IMG_DIM*IMG_DIM));

    // read mux, signed fields come back sign-extended
    always_comb
    begin
        rd_data = '0;
        if (in_img)
            rd_data = WB_DAT_W'($signed(image[off_img*PIX_W +: PIX_W]));
        else if (in_dwgt)
            rd_data = WB_DAT_W'($signed(dense_weights[off_dwgt*PIX_W +: PIX_W]));
        else if (in_filt)
            rd_data = WB_DAT_W'($signed(filt_weights[off_filt*PIX_W +: PIX_W]));
        else if (in_dbias)
            rd_data = WB_DAT_W'($signed(dense_biases[off_dbias*BIAS_W +: BIAS_W]));
        else if (in_score)
            rd_data = score_q[off_score*ACC_W +: ACC_W];
        else
        begin
            case (wb_adr)
                ADR_STATUS:     rd_data = {{(WB_DAT_W-2){1'b0}}, done_st, busy};
                ADR_CONV_BIAS:  rd_data = WB_DAT_W'($signed(conv_bias));
                ADR_CONV_SHIFT: rd_data = WB_DAT_W'(conv_shift);   // unsigned
                ADR_RESULT:     rd_data = WB_DAT_W'(class_q);
                default:        rd_data = '0;                      // ctrl and holes
            endcase
        end
    end

    // storage, low bits of the write data only
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            if (in_img)
                image[off_img*PIX_W +: PIX_W] <= wb_dat_w[PIX_W-1:0];
            if (in_dwgt)
                dense_weights[off_dwgt*PIX_W +: PIX_W] <= wb_dat_w[PIX_W-1:0];
            if (in_filt)
                filt_weights[off_filt*PIX_W +: PIX_W] <= wb_dat_w[PIX_W-1:0];
            if (in_dbias)
                dense_biases[off_dbias*BIAS_W +: BIAS_W] <= wb_dat_w[BIAS_W-1:0];
            if (wb_adr == ADR_CONV_BIAS)
                conv_bias <= wb_dat_w[BIAS_W-1:0];
            if (wb_adr == ADR_CONV_SHIFT)
                conv_shift <= wb_dat_w[SHIFT_W-1:0];
        end
        if (done)
        begin
            class_q <= result_class;    // hold results for readback
            score_q <= scores;
        end
        if (wb_req)
            wb_dat_r <= rd_data;        // presented with ack
    end

    // handshake, start pulse and status
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wb_ack  <= 1'b0;
            start   <= 1'b0;
            busy    <= 1'b0;
            done_st <= 1'b0;
        end
        else
        begin
            wb_ack <= wb_req;           // single-cycle ack
            start  <= start_req;
            if (start_req)
            begin
                busy    <= 1'b1;
                done_st <= 1'b0;        // new run hides old done
            end
            else if (done)
            begin
                busy    <= 1'b0;
                done_st <= 1'b1;
            end
        end
    end

endmodule

//--- design/cnn_top.sv
module cnn_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [cnn_pkg::WB_ADR_W-1:0] wb_adr,
    input  logic [cnn_pkg::WB_DAT_W-1:0] wb_dat_w,
    output logic [cnn_pkg::WB_DAT_W-1:0] wb_dat_r,
    output logic                         wb_ack
);
    import cnn_pkg::*;

    // config from the register block
    logic                                start;
    logic [IMG_DIM*IMG_DIM*PIX_W-1:0]    image;
    logic [KER_DIM*KER_DIM*PIX_W-1:0]    filt_weights;
    logic [BIAS_W-1:0]                   conv_bias;
    logic [SHIFT_W-1:0]                  conv_shift;
    logic [NUM_CLASS*NUM_FEAT*PIX_W-1:0] dense_weights;
    logic [NUM_CLASS*BIAS_W-1:0]         dense_biases;
    // feature stream
    logic                                feat_valid;
    logic [FEAT_IDX_W-1:0]               feat_index;
    logic [PIX_W-1:0]                    feat_data;
    // results back to the registers
    logic                                done;
    logic [CLASS_W-1:0]                  result_class;
    logic [NUM_CLASS*ACC_W-1:0]          scores;

    cnn_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .start        (start),
        .image        (image),
        .filt_weights (filt_weights),
        .conv_bias    (conv_bias),
        .conv_shift   (conv_shift),
        .dense_weights(dense_weights),
        .dense_biases (dense_biases),
        .done         (done),
        .result_class (result_class),
        .scores       (scores)
    );

    conv_pool u_conv_pool (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .image        (image),
        .filt_weights (filt_weights),
        .conv_bias    (conv_bias),
        .conv_shift   (conv_shift),
        .feat_valid   (feat_valid),
        .feat_index   (feat_index),
        .feat_data    (feat_data)
    );

    dense_argmax u_dense (
        .clk          (clk),
        .rst          (rst),
        .feat_valid   (feat_valid),
        .feat_index   (feat_index),
        .feat_data    (feat_data),
        .dense_weights(dense_weights),
        .dense_biases (dense_biases),
        .done         (done),
        .result_class (result_class),
        .scores       (scores)
    );

endmodule

//--- design/conv_pool.sv
module conv_pool (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               start,
    input  logic [cnn_pkg::IMG_DIM*cnn_pkg::IMG_DIM*cnn_pkg::PIX_W-1:0] image,
    input  logic [cnn_pkg::KER_DIM*cnn_pkg::KER_DIM*cnn_pkg::PIX_W-1:0] filt_weights,
    input  logic [cnn_pkg::BIAS_W-1:0]                         conv_bias,
    input  logic [cnn_pkg::SHIFT_W-1:0]                        conv_shift,
    output logic                                               feat_valid,
    output logic [cnn_pkg::FEAT_IDX_W-1:0]                     feat_index,
    output logic [cnn_pkg::PIX_W-1:0]                          feat_data
);
    import cnn_pkg::*;

    logic                     running;
    logic                     active;     // window evaluated this cycle
    logic [1:0]               prow;       // pooled row
    logic [1:0]               pcol;       // pooled column
    logic [1:0]               quad;       // 2x2 quadrant, {row, col}
    int                       base_r;
    int                       base_c;
    logic signed [PIX_W-1:0]  pix;
    logic signed [PIX_W-1:0]  wgt;
    logic signed [2*PIX_W-1:0] prod;
    logic signed [ACC_W-1:0]  sum;
    logic signed [ACC_W-1:0]  shifted;
    logic signed [PIX_W-1:0]  quant;
    logic signed [PIX_W-1:0]  cur_max;    // running max over quadrants
    logic signed [PIX_W-1:0]  cand;

    // first window already runs in the start cycle, counters idle at 0
    assign active = start | running;

    // **************************************************
    // 3x3 window, bias, requant
    // **************************************************
    always_comb
    begin
        base_r = 2 * int'(prow) + int'(quad[1]);
        base_c = 2 * int'(pcol) + int'(quad[0]);
        sum    = {{(ACC_W-BIAS_W){conv_bias[BIAS_W-1]}}, conv_bias};
        pix    = '0;
        wgt    = '0;
        prod   = '0;
        for (int i = 0; i < KER_DIM; i++)
        begin
            for (int j = 0; j < KER_DIM; j++)
            begin
                pix  = image[((base_r + i) * IMG_DIM + base_c + j) * PIX_W +: PIX_W];
                wgt  = filt_weights[(i * KER_DIM + j) * PIX_W +: PIX_W];
                prod = pix * wgt;
                sum  = sum + prod;          // sign-extended add
            end
        end
        shifted = sum >>> conv_shift;       // arithmetic
        if (shifted > SAT_MAX)
            quant = PIX_W'(SAT_MAX);
        else if (shifted < SAT_MIN)
            quant = PIX_W'(SAT_MIN);
        else
            quant = shifted[PIX_W-1:0];
        // quadrant 0 restarts the max
        cand = (quad == 2'd0 || quant > cur_max) ? quant : cur_max;
    end

    // position counters, one pass per start
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            running    <= 1'b0;
            quad       <= 2'd0;
            prow       <= 2'd0;
            pcol       <= 2'd0;
            feat_valid <= 1'b0;
        end
        else
        begin
            feat_valid <= 1'b0;
            if (start)
                running <= 1'b1;
            if (active)
            begin
                quad <= quad + 2'd1;
                if (quad == 2'd3)
                begin
                    feat_valid <= 1'b1;     // pooled feature complete
                    if (pcol == 2'(POOL_DIM - 1))
                    begin
                        pcol <= 2'd0;
                        if (prow == 2'(POOL_DIM - 1))
                        begin
                            prow    <= 2'd0;
                            running <= 1'b0;    // last window done
                        end
                        else
                            prow <= prow + 2'd1;
                    end
                    else
                        pcol <= pcol + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (active)
        begin
            cur_max <= cand;
            if (quad == 2'd3)
            begin
                feat_data  <= cand;
                feat_index <= FEAT_IDX_W'(int'(prow) * POOL_DIM + int'(pcol));
            end
        end
    end

endmodule

//--- design/dense_argmax.sv
module dense_argmax (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               feat_valid,
    input  logic [cnn_pkg::FEAT_IDX_W-1:0]                     feat_index,
    input  logic [cnn_pkg::PIX_W-1:0]                          feat_data,
    input  logic [cnn_pkg::NUM_CLASS*cnn_pkg::NUM_FEAT*cnn_pkg::PIX_W-1:0] dense_weights,
    input  logic [cnn_pkg::NUM_CLASS*cnn_pkg::BIAS_W-1:0]      dense_biases,
    output logic                                               done,
    output logic [cnn_pkg::CLASS_W-1:0]                        result_class,
    output logic [cnn_pkg::NUM_CLASS*cnn_pkg::ACC_W-1:0]       scores
);
    import cnn_pkg::*;

    logic [NUM_FEAT-1:0][PIX_W-1:0] feat_buf;   // pooled features
    logic                       last_feat;
    logic                       run;
    logic [CLASS_W-1:0]         cls;            // class scored this cycle
    logic signed [BIAS_W-1:0]   bias;
    logic signed [PIX_W-1:0]    f;
    logic signed [PIX_W-1:0]    w;
    logic signed [2*PIX_W-1:0]  prod;
    logic signed [ACC_W-1:0]    score;
    logic signed [ACC_W-1:0]    best_score;
    logic [CLASS_W-1:0]         best_cls;
    logic                       take;

    assign last_feat = feat_valid & (feat_index == FEAT_IDX_W'(NUM_FEAT - 1));

    always_ff @(posedge clk)
    begin
        if (feat_valid)
            feat_buf[feat_index] <= feat_data;
    end

    // **************************************************
    // one class per cycle, 9 taps plus bias
    // **************************************************
    always_comb
    begin
        bias  = dense_biases[cls*BIAS_W +: BIAS_W];
        score = bias;                   // sign-extended
        f     = '0;
        w     = '0;
        prod  = '0;
        for (int k = 0; k < NUM_FEAT; k++)
        begin
            f     = feat_buf[k];
            w     = dense_weights[(int'(cls) * NUM_FEAT + k) * PIX_W +: PIX_W];
            prod  = f * w;
            score = score + prod;
        end
        take = (cls == '0) || (score > best_score);   // strict, lower index keeps ties
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            run  <= 1'b0;
            cls  <= '0;
            done <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (last_feat)
            begin
                run <= 1'b1;
                cls <= '0;
            end
            else if (run)
            begin
                cls <= cls + 1'b1;
                if (cls == CLASS_W'(NUM_CLASS - 1))
                begin
                    run  <= 1'b0;
                    done <= 1'b1;       // all scores in place
                end
            end
        end
    end

    // scores and argmax
    always_ff @(posedge clk)
    begin
        if (run)
        begin
            scores[cls*ACC_W +: ACC_W] <= score;
            if (take)
            begin
                best_score <= score;
                best_cls   <= cls;
            end
            if (cls == CLASS_W'(NUM_CLASS - 1))
                result_class <= take ? cls : best_cls;
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the CNN testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -sv -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_cnn_top -f sources.f -o sim_cnn

./obj_dir/sim_cnn | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"

//--- sources.f
design/cnn_pkg.sv
design/cnn_regs.sv
design/conv_pool.sv
design/dense_argmax.sv
design/cnn_top.sv
verif/tb_cnn_model.sv
verif/tb_cnn_top.sv

//--- verif/tb_cnn_model.sv
package cnn_model_pkg;
    import cnn_pkg::*;

    // arithmetic shift, then clamp to signed 8 bit
    function automatic int requant(input int acc, input int shift);
        int v;
        v = acc >>> shift;
        if (v > SAT_MAX)
            v = SAT_MAX;
        else if (v < SAT_MIN)
            v = SAT_MIN;
        return v;
    endfunction

    // **************************************************
    // reference inference, conv -> pool -> dense -> argmax
    // **************************************************
    task automatic infer(
        input  int img [IMG_DIM*IMG_DIM],
        input  int filt [KER_DIM*KER_DIM],
        input  int cbias,
        input  int shift,
        input  int dwgt [NUM_CLASS*NUM_FEAT],
        input  int dbias [NUM_CLASS],
        output int score [NUM_CLASS],
        output int cls
    );
        int conv [CONV_DIM][CONV_DIM];
        int feat [NUM_FEAT];
        int acc;
        int m;
        // valid windows only, no padding
        for (int r = 0; r < CONV_DIM; r++)
        begin
            for (int c = 0; c < CONV_DIM; c++)
            begin
                acc = cbias;
                for (int i = 0; i < KER_DIM; i++)
                    for (int j = 0; j < KER_DIM; j++)
                        acc += img[(r + i) * IMG_DIM + c + j] * filt[i * KER_DIM + j];
                conv[r][c] = requant(acc, shift);
            end
        end
        // 2x2 max, row-major feature order
        for (int pr = 0; pr < POOL_DIM; pr++)
        begin
            for (int pc = 0; pc < POOL_DIM; pc++)
            begin
                m = conv[2 * pr][2 * pc];
                for (int dr = 0; dr < 2; dr++)
                    for (int dc = 0; dc < 2; dc++)
                        if (conv[2 * pr + dr][2 * pc + dc] > m)
                            m = conv[2 * pr + dr][2 * pc + dc];
                feat[pr * POOL_DIM + pc] = m;
            end
        end
        for (int k = 0; k < NUM_CLASS; k++)
        begin
            score[k] = dbias[k];
            for (int f = 0; f < NUM_FEAT; f++)
                score[k] += feat[f] * dwgt[k * NUM_FEAT + f];
        end
        cls = 0;    // first maximum wins
        for (int k = 1; k < NUM_CLASS; k++)
            if (score[k] > score[cls])
                cls = k;
    endtask

endpackage

//--- verif/tb_cnn_top.sv
module tb_cnn_top;
    timeunit 1ns;
    timeprecision 1ps;
    import cnn_pkg::*;
    import cnn_model_pkg::*;

    localparam int N_IMG       = IMG_DIM * IMG_DIM;
    localparam int N_FILT      = KER_DIM * KER_DIM;
    localparam int N_DWGT      = NUM_CLASS * NUM_FEAT;
    localparam int LOAD_OPS    = N_IMG + N_FILT + N_DWGT + NUM_CLASS + 2;
    localparam int RUN_OPS     = LOAD_OPS + 60;     // start, status polls, result reads
    localparam int NUM_RUNS    = 30;                // 20 random plus directed runs
    localparam int OP_CYCLES   = 4;                 // one bus op, drive to next drive
    localparam int CYCLE_LIMIT = 2 * OP_CYCLES * (2 * LOAD_OPS + NUM_RUNS * RUN_OPS);

    logic                clk;
    logic                rst;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [WB_ADR_W-1:0] wb_adr;
    logic [WB_DAT_W-1:0] wb_dat_w;
    logic [WB_DAT_W-1:0] wb_dat_r;
    logic                wb_ack;

    int seed = 62382;
    int cycle_count = 0;
    int err_count = 0;
    int tests_done = 0;
    int tests_failed = 0;

    // model copy of what was written
    int img [N_IMG];
    int filt [N_FILT];
    int cbias_m;
    int shift_m;
    int dwgt [N_DWGT];
    int dbias [NUM_CLASS];
    int exp_score [NUM_CLASS];
    int exp_class;

    cnn_top UUT (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns period
    end

    // watchdog
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check(input string name, input logic [WB_DAT_W-1:0] expected,
                         input logic [WB_DAT_W-1:0] actual);
        if (actual !== expected)
        begin
            $display("MISMATCH time %0t: %s expected %h actual %h", $time, name, expected,
                     actual);
            err_count++;
        end
    endtask

    // **************************************************
    // wishbone master
    // **************************************************
    // ack due one cycle after the request
    task automatic wait_ack();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!wb_ack)
        begin
            waited++;
            @(negedge clk);
        end
        check("wb_ack cycles to ack", 1, waited);
    endtask

    // drop the request, ack must be gone the next cycle
    task automatic release_bus();
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        check("wb_ack after one cycle", 0, wb_ack);
    endtask

    task automatic bus_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] dat);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        wait_ack();
        release_bus();
    endtask

    task automatic bus_read(input logic [WB_ADR_W-1:0] adr, output logic [WB_DAT_W-1:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        wait_ack();
        data = wb_dat_r;            // sampled mid-cycle
        release_bus();
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_done++;
        if (err_count != errs_before)
        begin
            tests_failed++;
            $display("test %s: FAIL, %0d errors", name, err_count - errs_before);
        end
        else
            $display("test %s: pass", name);
    endtask

    // random value in the signed range of a field
    function automatic int rand_signed(input int width);
        int r;
        r = $random(seed);
        return (r <<< (32 - width)) >>> (32 - width);
    endfunction

    // field value in the low bits, junk above it
    task automatic put_field(input logic [WB_ADR_W-1:0] adr, input int val, input int width);
        logic [WB_DAT_W-1:0] word;
        logic [WB_DAT_W-1:0] mask;
        mask = (WB_DAT_W'(1) << width) - 1;
        word = $random(seed);
        word = (word & ~mask) | (WB_DAT_W'(val) & mask);
        bus_write(adr, word);
    endtask

    task automatic randomize_config();
        foreach (img[i])
            img[i] = rand_signed(PIX_W);
        foreach (filt[i])
            filt[i] = rand_signed(PIX_W);
        foreach (dwgt[i])
            dwgt[i] = rand_signed(PIX_W);
        foreach (dbias[i])
            dbias[i] = rand_signed(BIAS_W);
        cbias_m = rand_signed(BIAS_W);
        shift_m = {$random(seed)} % 16;     // unsigned 4 bit
    endtask

    task automatic load_config();
        foreach (img[i])
            put_field(ADR_IMG_BASE + WB_ADR_W'(i), img[i], PIX_W);
        foreach (filt[i])
            put_field(ADR_FILT_BASE + WB_ADR_W'(i), filt[i], PIX_W);
        foreach (dwgt[i])
            put_field(ADR_DWGT_BASE + WB_ADR_W'(i), dwgt[i], PIX_W);
        foreach (dbias[i])
            put_field(ADR_DBIAS_BASE + WB_ADR_W'(i), dbias[i], BIAS_W);
        put_field(ADR_CONV_BIAS, cbias_m, BIAS_W);
        put_field(ADR_CONV_SHIFT, shift_m, SHIFT_W);
    endtask

    // poll status until done, watchdog covers a stuck run
    task automatic wait_done();
        logic [WB_DAT_W-1:0] rd;
        rd = '0;
        while (rd[1] != 1'b1)
            bus_read(ADR_STATUS, rd);
    endtask

    task automatic run_and_wait();
        bus_write(ADR_CTRL, WB_DAT_W'(1));
        wait_done();
    endtask

    task automatic check_results();
        logic [WB_DAT_W-1:0] rd;
        infer(img, filt, cbias_m, shift_m, dwgt, dbias, exp_score, exp_class);
        for (int k = 0; k < NUM_CLASS; k++)
        begin
            bus_read(ADR_SCORE_BASE + WB_ADR_W'(k), rd);
            check($sformatf("score[%0d]", k), exp_score[k], rd);
        end
        bus_read(ADR_RESULT, rd);
        check("result_class", exp_class, rd);
    endtask

    // **************************************************
    // tests
    // **************************************************
    task automatic test_status();
        logic [WB_DAT_W-1:0] rd;
        int errs;
        errs = err_count;
        bus_read(ADR_STATUS, rd);
        check("status after reset", 0, rd);
        randomize_config();
        load_config();
        bus_write(ADR_CTRL, WB_DAT_W'(1));
        bus_read(ADR_STATUS, rd);
        check("status busy", 1, rd);
        wait_done();
        bus_read(ADR_STATUS, rd);
        check("status done", 2, rd);
        bus_write(ADR_CTRL, WB_DAT_W'(1));     // second start hides done
        bus_read(ADR_STATUS, rd);
        check("status busy again", 1, rd);
        wait_done();
        bus_read(ADR_STATUS, rd);
        check("status done again", 2, rd);
        check_results();
        end_test("status", errs);
    endtask

    task automatic test_random_runs();
        int errs;
        errs = err_count;
        repeat (20)
        begin
            randomize_config();
            load_config();
            run_and_wait();
            check_results();
        end
        end_test("random inference", errs);
    endtask

    task automatic test_readback();
        logic [WB_DAT_W-1:0] rd;
        logic [WB_ADR_W-1:0] holes [10];
        int errs;
        errs = err_count;
        holes = '{8'h00, 8'h05, 8'h07, 8'h11, 8'h13, 8'h1c, 8'h3f, 8'h64, 8'hc0, 8'hff};
        randomize_config();
        load_config();
        foreach (img[i])
        begin
            bus_read(ADR_IMG_BASE + WB_ADR_W'(i), rd);
            check($sformatf("image[%0d]", i), img[i], rd);
        end
        foreach (filt[i])
        begin
            bus_read(ADR_FILT_BASE + WB_ADR_W'(i), rd);
            check($sformatf("filter[%0d]", i), filt[i], rd);
        end
        foreach (dwgt[i])
        begin
            bus_read(ADR_DWGT_BASE + WB_ADR_W'(i), rd);
            check($sformatf("dense_weight[%0d]", i), dwgt[i], rd);
        end
        foreach (dbias[i])
        begin
            bus_read(ADR_DBIAS_BASE + WB_ADR_W'(i), rd);
            check($sformatf("dense_bias[%0d]", i), dbias[i], rd);
        end
        bus_read(ADR_CONV_BIAS, rd);
        check("conv_bias", cbias_m, rd);
        bus_read(ADR_CONV_SHIFT, rd);
        check("conv_shift", shift_m, rd);      // zero-extended
        // scores are read only, still from the last run
        for (int k = 0; k < NUM_CLASS; k++)
        begin
            bus_write(ADR_SCORE_BASE + WB_ADR_W'(k), $random(seed));
            bus_read(ADR_SCORE_BASE + WB_ADR_W'(k), rd);
            check($sformatf("score[%0d] readback", k), exp_score[k], rd);
        end
        foreach (holes[i])
        begin
            bus_read(holes[i], rd);
            check($sformatf("unmapped %h", holes[i]), 0, rd);
        end
        end_test("register readback", errs);
    endtask

    task automatic test_saturation();
        logic [WB_DAT_W-1:0] rd;
        int errs;
        errs = err_count;
        foreach (img[i])
            img[i] = 1 + {$random(seed)} % 127;   // strictly positive pixels
        cbias_m = 0;
        shift_m = 0;
        foreach (dwgt[i])
            dwgt[i] = 1;
        foreach (dbias[i])
            dbias[i] = 0;
        foreach (filt[i])
            filt[i] = 127;
        load_config();
        run_and_wait();
        check_results();
        bus_read(ADR_SCORE_BASE, rd);
        check("score[0] at SAT_MAX", NUM_FEAT * SAT_MAX, rd);
        foreach (filt[i])
            filt[i] = -128;
        load_config();
        run_and_wait();
        check_results();
        bus_read(ADR_SCORE_BASE, rd);
        check("score[0] at SAT_MIN", NUM_FEAT * SAT_MIN, rd);
        end_test("saturation", errs);
    endtask

    task automatic test_ties();
        logic [WB_DAT_W-1:0] rd;
        int errs;
        int v;
        errs = err_count;
        randomize_config();
        foreach (dwgt[i])
            dwgt[i] = 0;
        v = rand_signed(BIAS_W);
        foreach (dbias[i])
            dbias[i] = v;                       // four-way tie
        load_config();
        run_and_wait();
        check_results();
        bus_read(ADR_RESULT, rd);
        check("tie of all classes", 0, rd);
        dbias = '{100, -50, 300, 300};          // class 2 and 3 tie on top
        load_config();
        run_and_wait();
        check_results();
        bus_read(ADR_RESULT, rd);
        check("tie of class 2 and 3", 2, rd);
        end_test("ties", errs);
    endtask

    task automatic test_busy_write();
        logic [WB_DAT_W-1:0] rd;
        int errs;
        errs = err_count;
        randomize_config();
        load_config();
        bus_write(ADR_CTRL, WB_DAT_W'(1));
        bus_read(ADR_STATUS, rd);
        check("status busy", 1, rd);
        bus_write(ADR_FILT_BASE, WB_DAT_W'(~filt[0]));  // must be dropped
        wait_done();
        bus_read(ADR_FILT_BASE, rd);
        check("filter[0] after busy write", filt[0], rd);
        check_results();                        // model keeps the old tap
        end_test("write while busy", errs);
    endtask

    initial
    begin
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_status();
        test_random_runs();
        test_readback();      // scores from the last random run
        test_saturation();
        test_ties();
        test_busy_write();
        $display("%0d tests, %0d failed, %0d mismatches", tests_done, tests_failed, err_count);
        if (err_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule
